/* hdl/lane_pkg.sv */
// Lane bring-up types
package lane_pkg;

  // bring-up states, link setup first, then training, then cl0
  typedef enum logic [3:0] {
    ST_DISABLED   = 4'd0,
    ST_CABLE_PROP = 4'd1,
    ST_DET_DEVICE = 4'd2,
    ST_PARAMETERS = 4'd3,
    ST_CLK_SWITCH = 4'd4,
    ST_GEN4_TS1   = 4'd5,
    ST_GEN4_TS2   = 4'd6,
    ST_GEN4_TS3   = 4'd7,
    ST_GEN4_TS4   = 4'd8,
    ST_GEN3_SLOS1 = 4'd9,
    ST_GEN3_SLOS2 = 4'd10,
    ST_GEN3_TS1   = 4'd11,
    ST_GEN3_TS2   = 4'd12,
    ST_CL0        = 4'd13
  } lane_state_e;

  typedef enum logic [1:0] {
    GEN4 = 2'd0,
    GEN3 = 2'd1,
    GEN2 = 2'd2                        // slowest
  } gen_speed_e;

  // lane content, used for both transmit select and received set
  typedef enum logic [3:0] {
    OS_GEN3_SLOS1 = 4'd0,
    OS_GEN3_SLOS2 = 4'd1,
    OS_GEN3_TS1   = 4'd2,
    OS_GEN3_TS2   = 4'd3,
    OS_GEN4_TS1   = 4'd4,
    OS_GEN4_TS2   = 4'd5,
    OS_GEN4_TS3   = 4'd6,
    OS_GEN4_TS4   = 4'd7,
    OS_DATA       = 4'd8,              // transport layer data
    OS_ZEROS      = 4'd9
  } os_sel_e;

  typedef struct packed {
    logic disabled_min;                // min time in disabled has passed
    logic training_error;
    logic gen4_ts1;
    logic gen4_ts2;
  } timer_flags_t;

  typedef struct packed {
    logic disabled;
    logic training;
    logic ts1_gen4;
    logic ts2_gen4;
  } lane_status_t;

  function automatic logic is_training_state(lane_state_e st);
    return st inside {ST_GEN4_TS1, ST_GEN4_TS2, ST_GEN4_TS3, ST_GEN4_TS4,
                      ST_GEN3_SLOS1, ST_GEN3_SLOS2, ST_GEN3_TS1, ST_GEN3_TS2};
  endfunction

endpackage

/* hdl/sideband_pkg.sv */
// Sideband transaction types
package sideband_pkg;

  // transaction select toward the sideband transmitter
  typedef enum logic [2:0] {
    TRANS_NONE   = 3'd0,
    TRANS_AT_REQ = 3'd2                // AT request for far adapter parameters
  } trans_sel_e;

  typedef struct packed {
    logic        valid;                // one-cycle pulse per received transaction
    logic        error;
    logic [23:0] payload;
  } at_rsp_t;

  localparam logic CFG_READ = 1'b1;

  // configuration space access
  typedef struct packed {
    logic [7:0] address;
    logic       read_write;            // 1 is read
  } cfg_req_t;

  typedef struct packed {
    trans_sel_e trans_sel;
    logic       disconnect;            // zeros on sbtx
  } sb_tx_t;

  localparam sb_tx_t SB_TX_RESET = '{trans_sel: TRANS_NONE, disconnect: 1'b1};

endpackage

/* hdl/lane_state_fsm.sv */
// Lane bring-up state machine
`timescale 1ns/1ps

module lane_state_fsm
(
  input  logic                   fsm_clk,
  input  logic                   reset_n,
  input  logic                   lane_disable_i,
  input  logic                   disconnect_sbrx_i,  // far side requests disconnect
  input  lane_pkg::timer_flags_t timers_i,
  input  sideband_pkg::at_rsp_t  at_rsp_i,
  input  logic                   usb4_cable_i,
  input  lane_pkg::gen_speed_e   gen_speed_i,
  input  logic                   stage_done_i,       // enough sets sent and far set seen
  output lane_pkg::lane_state_e  state_o
);

  import lane_pkg::*;

  lane_state_e state_q;
  lane_state_e state_nxt;
  logic        at_rsp_ok;

  assign at_rsp_ok = at_rsp_i.valid && !at_rsp_i.error;
  assign state_o   = state_q;

  //////////////////////////////
  // state register

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q <= ST_DISABLED;
    end
    else
    begin
      state_q <= state_nxt;
    end
  end

  //////////////////////////////
  // next-state logic

  always_comb
  begin
    state_nxt = state_q;
    case (state_q)
      ST_DISABLED:
        if (!lane_disable_i && timers_i.disabled_min)
          state_nxt = ST_CABLE_PROP;
      ST_CABLE_PROP:
        if (usb4_cable_i)
          state_nxt = ST_DET_DEVICE;
      ST_DET_DEVICE:
        if (!disconnect_sbrx_i)
          state_nxt = ST_PARAMETERS;
      ST_PARAMETERS:
        if (at_rsp_ok)
          state_nxt = ST_CLK_SWITCH;
      ST_CLK_SWITCH:
        state_nxt = (gen_speed_i == GEN4) ? ST_GEN4_TS1 : ST_GEN3_SLOS1;
      ST_GEN4_TS1:
        if (timers_i.gen4_ts1)
          state_nxt = ST_PARAMETERS;
        else if (stage_done_i)
          state_nxt = ST_GEN4_TS2;
      ST_GEN4_TS2:
        if (timers_i.gen4_ts2)
          state_nxt = ST_PARAMETERS;
        else if (stage_done_i)
          state_nxt = ST_GEN4_TS3;
      ST_GEN4_TS3:
        if (stage_done_i)
          state_nxt = ST_GEN4_TS4;
      ST_GEN4_TS4:
        if (stage_done_i)
          state_nxt = ST_CL0;
      ST_GEN3_SLOS1:
        if (stage_done_i)
          state_nxt = ST_GEN3_SLOS2;
      ST_GEN3_SLOS2:
        if (stage_done_i)
          state_nxt = ST_GEN3_TS1;
      ST_GEN3_TS1:
        if (stage_done_i)
          state_nxt = ST_GEN3_TS2;
      ST_GEN3_TS2:
        if (stage_done_i)
          state_nxt = ST_CL0;
      ST_CL0:
        state_nxt = ST_CL0;            // data on the lanes
      default:
        state_nxt = ST_DISABLED;
    endcase

    // common exits, later ones win
    if (is_training_state(state_q) && timers_i.training_error)
      state_nxt = ST_PARAMETERS;
    if (state_q > ST_DET_DEVICE && disconnect_sbrx_i)
      state_nxt = ST_DET_DEVICE;
    if (state_q != ST_DISABLED && lane_disable_i)
      state_nxt = ST_DISABLED;
  end

endmodule

/* hdl/link_param_negotiator.sv */
// Link speed negotiation
`timescale 1ns/1ps

module link_param_negotiator
#(
  parameter logic [7:0] CABLE_PROP_ADDR = 8'd18
)
(
  input  logic                   fsm_clk,
  input  logic                   reset_n,
  input  lane_pkg::lane_state_e  state_i,
  input  logic [31:0]            c_data_i,     // cable properties word
  input  sideband_pkg::at_rsp_t  at_rsp_i,
  output sideband_pkg::cfg_req_t cfg_req_o,
  output logic                   usb4_cable_o,
  output lane_pkg::gen_speed_e   gen_speed_o
);

  import lane_pkg::*;
  import sideband_pkg::*;

  gen_speed_e cable_gen;
  gen_speed_e far_gen;

  // lowest generation both ends support
  function automatic gen_speed_e slower_gen(gen_speed_e a, gen_speed_e b);
    if (a == GEN2 || b == GEN2)
      return GEN2;
    else if (a == GEN3 || b == GEN3)
      return GEN3;
    else
      return GEN4;
  endfunction

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      cfg_req_o    <= '{address: 8'h00, read_write: CFG_READ};
      usb4_cable_o <= 1'b0;
      cable_gen    <= GEN4;
      far_gen      <= GEN4;
      gen_speed_o  <= GEN4;
    end
    else
    begin
      case (state_i)
        ST_DISABLED:
        begin
          cfg_req_o    <= '{address: 8'h00, read_write: CFG_READ};
          usb4_cable_o <= 1'b0;
          cable_gen    <= GEN4;
          far_gen      <= GEN4;
          gen_speed_o  <= GEN4;
        end
        ST_CABLE_PROP:
        begin
          cfg_req_o    <= '{address: CABLE_PROP_ADDR, read_write: CFG_READ};
          usb4_cable_o <= (c_data_i[7:0] == 8'h40);
          if (c_data_i[21])
            cable_gen <= GEN4;
          else if (c_data_i[20])
            cable_gen <= GEN3;
          else
            cable_gen <= GEN2;
        end
        ST_PARAMETERS:
        begin
          // far adapter generation bits in the AT response
          if (at_rsp_i.payload[18])
            far_gen <= GEN4;
          else if (at_rsp_i.payload[13])
            far_gen <= GEN3;
          else
            far_gen <= GEN2;
          gen_speed_o <= slower_gen(cable_gen, far_gen);
        end
        default:
        begin
          gen_speed_o <= gen_speed_o;  // held through training
        end
      endcase
    end
  end

endmodule

/* hdl/os_exchange_tracker.sv */
// Ordered-set exchange tracker
`timescale 1ns/1ps

module os_exchange_tracker
#(
  parameter int GEN4_OS_COUNT = 16,
  parameter int GEN3_OS_COUNT = 32
)
(
  input  logic                   fsm_clk,
  input  logic                   reset_n,
  input  lane_pkg::lane_state_e  state_i,
  input  lane_pkg::os_sel_e      os_in_i,      // set seen on the receive lanes
  input  logic                   os_sent_i,    // pulse per set transmitted
  input  lane_pkg::gen_speed_e   gen_speed_i,
  output lane_pkg::os_sel_e      d_sel_o,
  output lane_pkg::lane_status_t status_o,
  output logic                   stage_done_o
);

  import lane_pkg::*;

  localparam int MAX_COUNT = (GEN4_OS_COUNT > GEN3_OS_COUNT) ? GEN4_OS_COUNT : GEN3_OS_COUNT;
  localparam int CNT_W     = $clog2(MAX_COUNT + 1);

  lane_state_e      state_d1;
  logic             stage_entry;
  logic [CNT_W-1:0] sent_cnt;
  logic [CNT_W-1:0] threshold;
  logic             os_matched;
  logic             count_done;

  function automatic os_sel_e stage_os(lane_state_e st);
    case (st)
      ST_GEN4_TS1:   return OS_GEN4_TS1;
      ST_GEN4_TS2:   return OS_GEN4_TS2;
      ST_GEN4_TS3:   return OS_GEN4_TS3;
      ST_GEN4_TS4:   return OS_GEN4_TS4;
      ST_GEN3_SLOS1: return OS_GEN3_SLOS1;
      ST_GEN3_SLOS2: return OS_GEN3_SLOS2;
      ST_GEN3_TS1:   return OS_GEN3_TS1;
      ST_GEN3_TS2:   return OS_GEN3_TS2;
      ST_CL0:        return OS_DATA;
      default:       return OS_ZEROS;
    endcase
  endfunction

  assign stage_entry = (state_i != state_d1);   // d_sel still shows the old set
  assign threshold   = (gen_speed_i == GEN4) ? CNT_W'(GEN4_OS_COUNT) : CNT_W'(GEN3_OS_COUNT);
  assign count_done  = (sent_cnt >= threshold);

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_d1     <= ST_DISABLED;
      sent_cnt     <= '0;
      os_matched   <= 1'b0;
      stage_done_o <= 1'b0;
      d_sel_o      <= OS_ZEROS;
      status_o     <= '{disabled: 1'b1, training: 1'b0, ts1_gen4: 1'b0, ts2_gen4: 1'b0};
    end
    else
    begin
      state_d1 <= state_i;
      if (stage_entry || !is_training_state(state_i))
      begin
        sent_cnt   <= '0;
        os_matched <= 1'b0;
      end
      else
      begin
        if (os_sent_i && !count_done)
          sent_cnt <= sent_cnt + 1'b1;   // saturates at threshold
        if (os_in_i == stage_os(state_i))
          os_matched <= 1'b1;
      end
      // one cycle high, the state moves on the same edge
      stage_done_o <= is_training_state(state_i) && !stage_entry && !stage_done_o &&
                      count_done && os_matched;
      d_sel_o           <= stage_os(state_i);
      status_o.disabled <= (state_i == ST_DISABLED);
      status_o.training <= is_training_state(state_i);
      status_o.ts1_gen4 <= (state_i == ST_GEN4_TS1);
      status_o.ts2_gen4 <= (state_i == ST_GEN4_TS2);
    end
  end

endmodule

/* hdl/at_request_ctrl.sv */
// AT request and sideband disconnect
`timescale 1ns/1ps

module at_request_ctrl
(
  input  logic                  fsm_clk,
  input  logic                  reset_n,
  input  lane_pkg::lane_state_e state_i,
  input  sideband_pkg::at_rsp_t at_rsp_i,
  input  logic                  sync_busy_i,   // pulse synchronizer still busy
  output sideband_pkg::sb_tx_t  sb_tx_o
);

  import lane_pkg::*;
  import sideband_pkg::*;

  lane_state_e state_d1;
  logic        armed_q;
  logic        in_params;
  logic        req_pending;

  assign in_params   = (state_i == ST_PARAMETERS);
  // armed on entry, re-armed by an errored response
  assign req_pending = in_params &&
                       (armed_q || state_d1 != ST_PARAMETERS ||
                        (at_rsp_i.valid && at_rsp_i.error));

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_d1 <= ST_DISABLED;
      armed_q  <= 1'b0;
      sb_tx_o  <= SB_TX_RESET;
    end
    else
    begin
      state_d1             <= state_i;
      armed_q              <= req_pending && sync_busy_i;   // wait out the synchronizer
      sb_tx_o.trans_sel    <= (req_pending && !sync_busy_i) ? TRANS_AT_REQ : TRANS_NONE;
      sb_tx_o.disconnect   <= (state_i == ST_DISABLED) || (state_i == ST_CABLE_PROP);
    end
  end

endmodule

/* hdl/usb4_lane_ctrl.sv */
// USB4 lane bring-up controller
`timescale 1ns/1ps

module usb4_lane_ctrl
#(
  parameter int         GEN4_OS_COUNT   = 16,
  parameter int         GEN3_OS_COUNT   = 32,
  parameter logic [7:0] CABLE_PROP_ADDR = 8'd18
)
(
  input  logic                   fsm_clk,
  input  logic                   reset_n,
  input  lane_pkg::os_sel_e      os_in_i,
  input  logic                   os_sent_i,
  input  logic                   disconnect_sbrx_i,
  input  logic                   lane_disable_i,
  input  lane_pkg::timer_flags_t timers_i,
  input  sideband_pkg::at_rsp_t  at_rsp_i,
  input  logic [31:0]            c_data_i,
  input  logic                   sync_busy_i,
  output lane_pkg::os_sel_e      d_sel_o,
  output lane_pkg::gen_speed_e   gen_speed_o,
  output lane_pkg::lane_status_t status_o,
  output sideband_pkg::cfg_req_t cfg_req_o,
  output sideband_pkg::sb_tx_t   sb_tx_o
);

  import lane_pkg::*;

  lane_state_e state;
  logic        stage_done;
  logic        usb4_cable;

  lane_state_fsm i_lane_state_fsm (
    .fsm_clk           (fsm_clk),
    .reset_n           (reset_n),
    .lane_disable_i    (lane_disable_i),
    .disconnect_sbrx_i (disconnect_sbrx_i),
    .timers_i          (timers_i),
    .at_rsp_i          (at_rsp_i),
    .usb4_cable_i      (usb4_cable),
    .gen_speed_i       (gen_speed_o),
    .stage_done_i      (stage_done),
    .state_o           (state)
  );

  link_param_negotiator #(
    .CABLE_PROP_ADDR (CABLE_PROP_ADDR)
  ) i_link_param_negotiator (
    .fsm_clk      (fsm_clk),
    .reset_n      (reset_n),
    .state_i      (state),
    .c_data_i     (c_data_i),
    .at_rsp_i     (at_rsp_i),
    .cfg_req_o    (cfg_req_o),
    .usb4_cable_o (usb4_cable),
    .gen_speed_o  (gen_speed_o)
  );

  os_exchange_tracker #(
    .GEN4_OS_COUNT (GEN4_OS_COUNT),
    .GEN3_OS_COUNT (GEN3_OS_COUNT)
  ) i_os_exchange_tracker (
    .fsm_clk      (fsm_clk),
    .reset_n      (reset_n),
    .state_i      (state),
    .os_in_i      (os_in_i),
    .os_sent_i    (os_sent_i),
    .gen_speed_i  (gen_speed_o),
    .d_sel_o      (d_sel_o),
    .status_o     (status_o),
    .stage_done_o (stage_done)
  );

  at_request_ctrl i_at_request_ctrl (
    .fsm_clk     (fsm_clk),
    .reset_n     (reset_n),
    .state_i     (state),
    .at_rsp_i    (at_rsp_i),
    .sync_busy_i (sync_busy_i),
    .sb_tx_o     (sb_tx_o)
  );

endmodule

/* verif/lane_ctrl_assertions.sv */
// Lane controller output checks
`timescale 1ns/1ps

module lane_ctrl_assertions
(
  input logic                   fsm_clk,
  input logic                   reset_n,
  input lane_pkg::os_sel_e      d_sel_i,
  input lane_pkg::gen_speed_e   gen_speed_i,
  input lane_pkg::lane_status_t status_i,
  input sideband_pkg::sb_tx_t   sb_tx_i
);

  import lane_pkg::*;
  import sideband_pkg::*;

  a_zeros_when_disabled: assert property (@(posedge fsm_clk) disable iff (!reset_n)
    status_i.disabled |-> (d_sel_i == OS_ZEROS))
    else $error("d_sel_o is not zeros while status_o.disabled is set");

  // the far side cannot see a request while sbtx is held in disconnect
  a_no_req_in_disconnect: assert property (@(posedge fsm_clk) disable iff (!reset_n)
    sb_tx_i.disconnect |-> (sb_tx_i.trans_sel == TRANS_NONE))
    else $error("AT request issued while sideband disconnect is high");

  a_speed_stable_training: assert property (@(posedge fsm_clk) disable iff (!reset_n)
    status_i.training |-> $stable(gen_speed_i))
    else $error("gen_speed_o changed during training");

endmodule

/* verif/lane_ctrl_tb.sv */
// Lane controller testbench
`timescale 1ns/1ps

module lane_ctrl_tb;

  import lane_pkg::*;
  import sideband_pkg::*;

  localparam int GEN4_N = 16;
  localparam int GEN3_N = 32;
  localparam int WAIT_LIMIT = 400;
  localparam logic [1:0] EXIT_NONE = 2'd0;
  localparam logic [1:0] EXIT_DISC = 2'd1;             // far disconnect in cl0
  localparam logic [1:0] EXIT_TERR = 2'd2;             // training error timeout
  localparam logic [0:4][3:0] SEQ_GEN4 =
    {OS_GEN4_TS1, OS_GEN4_TS2, OS_GEN4_TS3, OS_GEN4_TS4, OS_DATA};
  localparam logic [0:4][3:0] SEQ_GEN3 =
    {OS_GEN3_SLOS1, OS_GEN3_SLOS2, OS_GEN3_TS1, OS_GEN3_TS2, OS_DATA};
  localparam lane_status_t STATUS_OFF = '{disabled: 1'b1, training: 1'b0,
                                          ts1_gen4: 1'b0, ts2_gen4: 1'b0};
  localparam sb_tx_t SB_DISC = '{trans_sel: TRANS_NONE, disconnect: 1'b1};
  localparam sb_tx_t SB_CONN = '{trans_sel: TRANS_NONE, disconnect: 1'b0};

  typedef struct packed {
    logic [31:0]     cable;
    logic [23:0]     payload;
    logic            err_first;
    gen_speed_e      exp_gen;
    logic [0:4][3:0] seq;
    logic [1:0]      exit_kind;
  } row_t;

  // output levels the testbench waits for
  typedef enum logic [1:0] {
    LVL_CFG_READ,
    LVL_SB_CONNECTED,
    LVL_DISABLED
  } level_e;

  logic fsm_clk, reset_n, os_sent_i, disconnect_sbrx_i, lane_disable_i, sync_busy_i;
  os_sel_e      os_in_i;
  timer_flags_t timers_i;
  at_rsp_t      at_rsp_i;
  logic [31:0]  c_data_i;
  os_sel_e      d_sel_o;
  gen_speed_e   gen_speed_o;
  lane_status_t status_o;
  cfg_req_t     cfg_req_o;
  sb_tx_t       sb_tx_o;

  // staged values, applied on the next rising edge
  logic         reset_s, lane_disable_s, disc_sbrx_s;
  timer_flags_t timers_s;
  at_rsp_t      rsp_s;
  logic [31:0]  cable_s;
  bit           busy_rand, busy_prev, busy_now, match_given, exit_ok;
  os_sel_e      d_sel_seen, cur_stage;
  int           sent_cnt, match_after, at_pulses, retry_base;
  row_t         rows [5];

  usb4_lane_ctrl #(.GEN4_OS_COUNT(GEN4_N), .GEN3_OS_COUNT(GEN3_N),
                   .CABLE_PROP_ADDR(8'd18)) i_usb4_lane_ctrl (.*);

  bind usb4_lane_ctrl lane_ctrl_assertions i_lane_ctrl_assertions (
    .fsm_clk     (fsm_clk),
    .reset_n     (reset_n),
    .d_sel_i     (d_sel_o),
    .gen_speed_i (gen_speed_o),
    .status_i    (status_o),
    .sb_tx_i     (sb_tx_o)
  );

  initial
  begin
    fsm_clk = 1'b0;
    forever #4 fsm_clk = ~fsm_clk;
  end

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "run stopped");
  endtask

  initial
  begin
    #1ms;
    fail_now("simulation ran past its time limit");
  end

  function automatic bit is_train_os(os_sel_e os);
    return os <= OS_GEN4_TS4;
  endfunction

  function automatic int stage_threshold(os_sel_e os);
    return (os >= OS_GEN4_TS1 && os <= OS_GEN4_TS4) ? GEN4_N : GEN3_N;
  endfunction

  function automatic lane_status_t expected_status(os_sel_e os);
    return '{disabled: 1'b0, training: is_train_os(os),
             ts1_gen4: (os == OS_GEN4_TS1), ts2_gen4: (os == OS_GEN4_TS2)};
  endfunction

  function automatic bit level_reached(level_e lvl);
    case (lvl)
      LVL_CFG_READ:     return cfg_req_o.address == 8'd18;
      LVL_SB_CONNECTED: return !sb_tx_o.disconnect;
      default:          return status_o.disabled;
    endcase
  endfunction

  //////////////////////////////
  // compare tasks

  task automatic check_os_sel(os_sel_e got, os_sel_e exp);
    if (got !== exp)
      fail_now($sformatf("MISMATCH at %0t: d_sel_o is %s, expected %s",
                         $time, got.name(), exp.name()));
  endtask

  task automatic check_gen_speed(gen_speed_e got, gen_speed_e exp);
    if (got !== exp)
      fail_now($sformatf("MISMATCH at %0t: gen_speed_o is %s, expected %s",
                         $time, got.name(), exp.name()));
  endtask

  task automatic check_status(lane_status_t got, lane_status_t exp);
    if (got !== exp)
      fail_now($sformatf("MISMATCH at %0t: status_o is %b, expected %b", $time, got, exp));
  endtask

  task automatic check_sb_tx(sb_tx_t got, sb_tx_t exp);
    if (got !== exp)
      fail_now($sformatf("MISMATCH at %0t: sb_tx_o is %b, expected %b", $time, got, exp));
  endtask

  task automatic check_cfg_req(cfg_req_t got, cfg_req_t exp);
    if (got !== exp)
      fail_now($sformatf("MISMATCH at %0t: cfg_req_o is %h, expected %h", $time, got, exp));
  endtask

  task automatic check_reset_outputs();
    check_os_sel(d_sel_o, OS_ZEROS);
    check_gen_speed(gen_speed_o, GEN4);
    check_status(status_o, STATUS_OFF);
    check_cfg_req(cfg_req_o, '{address: 8'h00, read_write: 1'b1});
    check_sb_tx(sb_tx_o, SB_DISC);
  endtask

  //////////////////////////////
  // one clock, with the ordered-set responder

  task automatic next_cycle();
    bit send;
    @(posedge fsm_clk);
    send = is_train_os(cur_stage) && ($urandom % 4 != 0);              // random idle gaps
    if (is_train_os(cur_stage) && sent_cnt >= match_after)
      match_given = 1'b1;
    busy_prev = busy_now;
    busy_now  = busy_rand && ($urandom % 3 == 0);
    reset_n           <= reset_s;
    os_sent_i         <= send;
    os_in_i           <= match_given ? cur_stage : OS_ZEROS;
    sync_busy_i       <= busy_now;
    lane_disable_i    <= lane_disable_s;
    disconnect_sbrx_i <= disc_sbrx_s;
    timers_i          <= timers_s;
    at_rsp_i          <= rsp_s;
    c_data_i          <= cable_s;
    @(negedge fsm_clk);
    d_sel_seen = d_sel_o;
    if (d_sel_seen != cur_stage)
    begin
      if (is_train_os(cur_stage) && !exit_ok &&
          (sent_cnt < stage_threshold(cur_stage) || !match_given))
        fail_now($sformatf("stage %s ended after %0d sets, far set matched %0d",
                           cur_stage.name(), sent_cnt, match_given));
      exit_ok     = 1'b0;
      cur_stage   = d_sel_seen;
      sent_cnt    = 0;
      match_given = 1'b0;
      match_after = int'($urandom % (stage_threshold(cur_stage) + 4));  // far match early or late
    end
    if (send)
      sent_cnt++;                                      // pulse high while d_sel_seen is shown
    if (sb_tx_o.trans_sel == TRANS_AT_REQ)
    begin
      if (busy_prev)
        fail_now("AT request was issued while sync_busy_i was high");
      at_pulses++;
    end
  endtask

  task automatic wait_d_sel_leaves(os_sel_e from, string what);
    int n;
    n = 0;
    while (d_sel_seen == from)
    begin
      if (n == WAIT_LIMIT)
        fail_now($sformatf("timed out waiting for %s", what));
      n++;
      next_cycle();
    end
  endtask

  task automatic wait_at_pulses(int target);
    int n;
    n = 0;
    while (at_pulses < target)
    begin
      if (n == WAIT_LIMIT)
        fail_now("timed out waiting for an AT request");
      n++;
      next_cycle();
    end
  endtask

  task automatic wait_level(level_e lvl, string what);
    int n;
    n = 0;
    while (!level_reached(lvl))
    begin
      if (n == WAIT_LIMIT)
        fail_now($sformatf("timed out waiting for %s", what));
      n++;
      next_cycle();
    end
  endtask

  task automatic send_response(bit err);
    rsp_s.valid = 1'b1;
    rsp_s.error = err;
    next_cycle();
    rsp_s.valid = 1'b0;
    rsp_s.error = 1'b0;
  endtask

  task automatic do_params(row_t r, int base);
    int expect_n;
    expect_n = base + 1;
    wait_at_pulses(expect_n);
    if (r.err_first)
    begin
      repeat (3) next_cycle();
      send_response(1'b1);                                  // error re-arms the request
      expect_n++;
      wait_at_pulses(expect_n);
    end
    repeat (3) next_cycle();
    if (at_pulses != expect_n)
      fail_now("AT request was issued more than once for one arming");
    send_response(1'b0);
    busy_rand = 1'b0;
  endtask

  task automatic run_training(row_t r, bit abort);
    os_sel_e prev;
    prev = OS_ZEROS;
    for (int i = 0; i < 5; i++)
    begin
      wait_d_sel_leaves(prev, "the next training stage");
      check_os_sel(d_sel_seen, os_sel_e'(r.seq[i]));
      prev = d_sel_seen;
      check_gen_speed(gen_speed_o, r.exp_gen);
      check_status(status_o, expected_status(prev));
      if (abort && i == 1)
      begin
        exit_ok                 = 1'b1;
        busy_rand               = 1'b1;
        retry_base              = at_pulses;
        timers_s.training_error = 1'b1;
        next_cycle();
        timers_s.training_error = 1'b0;
        wait_d_sel_leaves(prev, "the training error exit");
        check_os_sel(d_sel_seen, OS_ZEROS);
        return;
      end
    end
  endtask

  task automatic run_row(row_t r);
    int base;
    cable_s = r.cable;
    rsp_s   = '{valid: 1'b0, error: 1'b0, payload: r.payload};   // held long before the pulse
    disc_sbrx_s           = 1'b1;
    lane_disable_s        = 1'b0;
    timers_s.disabled_min = 1'b1;
    wait_level(LVL_CFG_READ, "the cable properties read");
    check_cfg_req(cfg_req_o, '{address: 8'd18, read_write: 1'b1});
    timers_s.disabled_min = 1'b0;
    if (r.cable[7:0] != 8'h40)
    begin
      repeat (40)
      begin
        next_cycle();
        check_os_sel(d_sel_o, OS_ZEROS);
        check_sb_tx(sb_tx_o, SB_DISC);
      end
    end
    else
    begin
      wait_level(LVL_SB_CONNECTED, "sideband disconnect to fall");
      check_sb_tx(sb_tx_o, SB_CONN);
      busy_rand   = 1'b1;
      base        = at_pulses;
      disc_sbrx_s = 1'b0;
      do_params(r, base);
      run_training(r, r.exit_kind == EXIT_TERR);
      if (r.exit_kind == EXIT_TERR)
      begin
        do_params(r, retry_base);
        run_training(r, 1'b0);
      end
      if (r.exit_kind == EXIT_DISC)
      begin
        disc_sbrx_s = 1'b1;
        wait_d_sel_leaves(OS_DATA, "the disconnect exit from CL0");
        check_os_sel(d_sel_seen, OS_ZEROS);
      end
    end
    lane_disable_s        = 1'b1;
    timers_s.disabled_min = 1'b1;                      // lane_disable alone holds disabled
    wait_level(LVL_DISABLED, "status_o.disabled after lane disable");
    repeat (3)
    begin
      check_reset_outputs();
      next_cycle();
    end
  endtask

  //////////////////////////////
  // main sequence

  initial
  begin
    void'($urandom(32'he6bc));
    rows[0] = '{32'h0020_0040, 24'h04_0000, 1'b0, GEN4, SEQ_GEN4, EXIT_NONE};
    rows[1] = '{32'h0020_0040, 24'h00_2000, 1'b1, GEN3, SEQ_GEN3, EXIT_DISC};
    rows[2] = '{32'h0010_0040, 24'h04_0000, 1'b0, GEN3, SEQ_GEN3, EXIT_TERR};
    rows[3] = '{32'h0000_0040, 24'h04_2000, 1'b1, GEN2, SEQ_GEN3, EXIT_NONE};
    rows[4] = '{32'h0020_0041, 24'h04_0000, 1'b0, GEN4, SEQ_GEN4, EXIT_NONE};
    reset_n = 1'b0;
    os_in_i = OS_ZEROS;
    os_sent_i = 1'b0;
    disconnect_sbrx_i = 1'b1;
    lane_disable_i = 1'b1;
    timers_i = '0;
    at_rsp_i = '0;
    c_data_i = '0;
    sync_busy_i = 1'b0;
    reset_s = 1'b0;
    lane_disable_s = 1'b1;
    disc_sbrx_s = 1'b1;
    timers_s = '0;
    rsp_s = '0;
    cable_s = '0;
    d_sel_seen = OS_ZEROS;
    cur_stage = OS_ZEROS;
    repeat (5) next_cycle();
    reset_s = 1'b1;
    repeat (5)
    begin
      next_cycle();
      check_reset_outputs();
    end
    lane_disable_s = 1'b0;                             // disabled_min still low
    repeat (5)
    begin
      next_cycle();
      check_reset_outputs();
    end
    foreach (rows[k])
      run_row(rows[k]);
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* files.f */
hdl/lane_pkg.sv
hdl/sideband_pkg.sv
hdl/lane_state_fsm.sv
hdl/link_param_negotiator.sv
hdl/os_exchange_tracker.sv
hdl/at_request_ctrl.sv
hdl/usb4_lane_ctrl.sv
verif/lane_ctrl_assertions.sv
verif/lane_ctrl_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module lane_ctrl_tb -f files.f
	./obj_dir/Vlane_ctrl_tb > sim.log 2>&1 || true
	@if grep -q "Finished with errors" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log
